// ==== gcn_settings.svh ====
`ifndef GCN_SETTINGS_SVH
`define GCN_SETTINGS_SVH

// graph and layer sizes
`define GCN_NODES    6
`define GCN_EDGES    6   // entries in the coo edge list
`define GCN_FEATS    16  // feature columns == weight rows
`define GCN_CLASSES  3

// datapath widths
`define GCN_NODE_W   3   // id 0 marks an unused edge entry
`define GCN_DATA_W   5   // unsigned features and weights
`define GCN_AGG_W    8   // holds GCN_NODES * max feature
`define GCN_ACC_W    17  // holds GCN_FEATS * max agg * max weight
`define GCN_ADDR_W   4
`define GCN_CLASS_W  2

`endif

// ==== gcn_pkg.sv ====
`include "gcn_settings.svh"

package gcn_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_build,
        st_stream,
        st_wait
    } gcn_state_t;

    typedef logic [`GCN_NODE_W-1:0]  node_id_t;
    typedef logic [`GCN_DATA_W-1:0]  feat_t;
    typedef logic [`GCN_AGG_W-1:0]   agg_t;
    typedef logic [`GCN_ACC_W-1:0]   acc_t;
    typedef logic [`GCN_ADDR_W-1:0]  col_addr_t;
    typedef logic [`GCN_CLASS_W-1:0] class_idx_t;

endpackage

// ==== gcn_sequencer.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_sequencer
    import gcn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      result_ready,
    output logic      clear,
    output logic      build_en,
    output logic      feat_re,
    output logic      col_valid,
    output logic      col_last,
    output col_addr_t feat_addr
);

    localparam int BUILD_W = $clog2(`GCN_EDGES);

    gcn_state_t         state, state_nxt;
    logic [BUILD_W-1:0] build_cnt;
    col_addr_t          col_cnt;
    logic               build_done, stream_done;

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////
    assign build_done  = (build_cnt == BUILD_W'(`GCN_EDGES - 1));
    assign stream_done = (col_cnt == col_addr_t'(`GCN_FEATS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:   if (start) state_nxt = st_build;
            st_build:  if (build_done) state_nxt = st_stream;
            st_stream: if (stream_done) state_nxt = st_wait;
            st_wait:   if (result_ready) state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            build_cnt <= '0;
            col_cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (clear)
                build_cnt <= '0;
            else if (build_en)
                build_cnt <= build_cnt + 1'b1;
            if (build_en)
                col_cnt <= '0;   // stream always starts at column 0
            else if (feat_re)
                col_cnt <= col_cnt + 1'b1;
        end
    end

    // start only counts while idle
    assign clear     = start && (state == st_idle);
    assign build_en  = (state == st_build);
    assign feat_re   = (state == st_stream);
    assign feat_addr = col_cnt;

    // memories answer one cycle later, so tag the returned column then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_valid <= 1'b0;
            col_last  <= 1'b0;
        end else begin
            col_valid <= feat_re;
            col_last  <= feat_re && stream_done;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(feat_re && build_en));

    // argmax may only finish while a run is outstanding
    a_ready_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        result_ready |-> (state == st_wait));

endmodule

// ==== gcn_adjacency.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_adjacency
    import gcn_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  logic                                   clear,
    input  logic                                   build_en,
    input  node_id_t [`GCN_EDGES-1:0]              edge_src,
    input  node_id_t [`GCN_EDGES-1:0]              edge_dst,
    output logic [`GCN_NODES-1:0][`GCN_NODES-1:0]  adj
);

    localparam int PTR_W = $clog2(`GCN_EDGES);

    node_id_t [`GCN_EDGES-1:0] src_r, dst_r;   // captured edge list
    logic [PTR_W-1:0]          ptr;
    node_id_t                  a, b;
    node_id_t                  ia, ib;
    logic                      ids_ok;

    assign a  = src_r[ptr];
    assign b  = dst_r[ptr];
    assign ia = a - node_id_t'(1);   // ids are 1-based
    assign ib = b - node_id_t'(1);

    always_ff @(posedge clk) begin
        if (clear) begin
            src_r <= edge_src;
            dst_r <= edge_dst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj <= '0;
            ptr <= '0;
        end else if (clear) begin
            adj <= '0;
            ptr <= '0;
        end else if (build_en) begin
            ptr <= ptr + 1'b1;
            if (a != '0 && b != '0) begin   // zero marks an unused entry
                adj[ia][ib] <= 1'b1;
                adj[ib][ia] <= 1'b1;
            end
        end
    end

    always_comb begin
        ids_ok = 1'b1;
        for (int e = 0; e < `GCN_EDGES; e++)
            if (edge_src[e] > node_id_t'(`GCN_NODES) || edge_dst[e] > node_id_t'(`GCN_NODES))
                ids_ok = 1'b0;
    end

    // every captured id names a real node
    a_ids_legal: assert property (@(posedge clk) disable iff (!rst_n)
        clear |-> ids_ok);

endmodule

// ==== gcn_aggregate.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_aggregate
    import gcn_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   col_valid,
    input  logic                                   col_last,
    input  logic [`GCN_NODES-1:0][`GCN_NODES-1:0]  adj,
    input  feat_t [`GCN_NODES-1:0]                 feat_col,
    input  feat_t [`GCN_CLASSES-1:0]               weight_row,
    output logic                                   agg_valid,
    output logic                                   agg_last,
    output agg_t [`GCN_NODES-1:0]                  agg_sum,
    output feat_t [`GCN_CLASSES-1:0]               agg_weight
);

    agg_t [`GCN_NODES-1:0] sum_nxt;

    // neighbour sum of the current column, one adder tree per node
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            sum_nxt[n] = '0;
            for (int m = 0; m < `GCN_NODES; m++)
                if (adj[n][m])
                    sum_nxt[n] = sum_nxt[n] + agg_t'(feat_col[m]);
        end
    end

    always_ff @(posedge clk) begin
        if (col_valid) begin
            agg_sum    <= sum_nxt;
            agg_weight <= weight_row;   // keep weights aligned with their column
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agg_valid <= 1'b0;
            agg_last  <= 1'b0;
        end else begin
            agg_valid <= col_valid;
            agg_last  <= col_valid && col_last;
        end
    end

endmodule

// ==== gcn_transform.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_transform
    import gcn_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     clear,
    input  logic                                     agg_valid,
    input  logic                                     agg_last,
    input  agg_t [`GCN_NODES-1:0]                    agg_sum,
    input  feat_t [`GCN_CLASSES-1:0]                 agg_weight,
    output acc_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0]  score,
    output logic                                     score_last
);

    acc_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0] prod;

    // outer product of the neighbour sums and the weight row
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++)
            for (int c = 0; c < `GCN_CLASSES; c++)
                prod[n][c] = acc_t'(agg_sum[n]) * acc_t'(agg_weight[c]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score      <= '0;
            score_last <= 1'b0;
        end else begin
            score_last <= agg_valid && agg_last;   // scores are final next cycle
            if (clear) begin
                score <= '0;
            end else if (agg_valid) begin
                for (int n = 0; n < `GCN_NODES; n++)
                    for (int c = 0; c < `GCN_CLASSES; c++)
                        score[n][c] <= score[n][c] + prod[n][c];
            end
        end
    end

    // a new run must never start with a column still in the pipe
    a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
        clear |-> !agg_valid);

endmodule

// ==== gcn_argmax.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_argmax
    import gcn_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     clear,
    input  logic                                     score_last,
    input  acc_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0]  score,
    output class_idx_t [`GCN_NODES-1:0]              y,
    output logic                                     done,
    output logic                                     result_ready
);

    localparam class_idx_t LAST_CLS = class_idx_t'(`GCN_CLASSES - 1);

    logic                        busy;
    class_idx_t                  cls;        // class under inspection
    acc_t [`GCN_NODES-1:0]       best_val, val_nxt;
    class_idx_t [`GCN_NODES-1:0] best_idx, idx_nxt;
    logic                        y_ok;

    // strict compare keeps the lower index on a tie
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (cls == '0 || score[n][cls] > best_val[n]) begin
                val_nxt[n] = score[n][cls];
                idx_nxt[n] = cls;
            end else begin
                val_nxt[n] = best_val[n];
                idx_nxt[n] = best_idx[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            best_val <= val_nxt;
            best_idx <= idx_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            cls          <= '0;
            y            <= '0;
            done         <= 1'b0;
            result_ready <= 1'b0;
        end else begin
            result_ready <= 1'b0;
            if (clear) begin
                busy <= 1'b0;
                done <= 1'b0;
            end else if (score_last) begin
                busy <= 1'b1;
                cls  <= '0;
            end else if (busy) begin
                if (cls == LAST_CLS) begin
                    busy         <= 1'b0;
                    y            <= idx_nxt;   // result held until next start
                    done         <= 1'b1;
                    result_ready <= 1'b1;
                end else begin
                    cls <= cls + 1'b1;
                end
            end
        end
    end

    always_comb begin
        y_ok = 1'b1;
        for (int n = 0; n < `GCN_NODES; n++)
            if (y[n] > LAST_CLS)
                y_ok = 1'b0;
    end

    a_y_range: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> y_ok);

endmodule

// ==== gcn_top.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_top
    import gcn_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  node_id_t [`GCN_EDGES-1:0]    edge_src,
    input  node_id_t [`GCN_EDGES-1:0]    edge_dst,
    input  feat_t [`GCN_NODES-1:0]       feat_col,
    input  feat_t [`GCN_CLASSES-1:0]     weight_row,
    output logic                         feat_re,
    output col_addr_t                    feat_addr,
    output class_idx_t [`GCN_NODES-1:0]  y,
    output logic                         done
);

    ////////////////////////////////////////////////////////////////////////////
    // stage interconnect
    ////////////////////////////////////////////////////////////////////////////
    logic                                     clear;
    logic                                     build_en;
    logic                                     col_valid, col_last;
    logic [`GCN_NODES-1:0][`GCN_NODES-1:0]    adj;
    logic                                     agg_valid, agg_last;
    agg_t [`GCN_NODES-1:0]                    agg_sum;
    feat_t [`GCN_CLASSES-1:0]                 agg_weight;
    acc_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0]  score;
    logic                                     score_last;
    logic                                     result_ready;

    gcn_sequencer i_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .result_ready (result_ready),
        .clear        (clear),
        .build_en     (build_en),
        .feat_re      (feat_re),
        .col_valid    (col_valid),
        .col_last     (col_last),
        .feat_addr    (feat_addr)
    );

    gcn_adjacency i_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .clear    (clear),
        .build_en (build_en),
        .edge_src (edge_src),
        .edge_dst (edge_dst),
        .adj      (adj)
    );

    gcn_aggregate i_agg (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_valid  (col_valid),
        .col_last   (col_last),
        .adj        (adj),
        .feat_col   (feat_col),
        .weight_row (weight_row),
        .agg_valid  (agg_valid),
        .agg_last   (agg_last),
        .agg_sum    (agg_sum),
        .agg_weight (agg_weight)
    );

    gcn_transform i_xfm (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .agg_valid  (agg_valid),
        .agg_last   (agg_last),
        .agg_sum    (agg_sum),
        .agg_weight (agg_weight),
        .score      (score),
        .score_last (score_last)
    );

    gcn_argmax i_argmax (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .score_last   (score_last),
        .score        (score),
        .y            (y),
        .done         (done),
        .result_ready (result_ready)
    );

endmodule

// ==== gcn_checker.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module gcn_checker
    import gcn_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     start,
    input  node_id_t [`GCN_EDGES-1:0]                edge_src,
    input  node_id_t [`GCN_EDGES-1:0]                edge_dst,
    input  feat_t [`GCN_FEATS-1:0][`GCN_NODES-1:0]   feat_tab,
    input  feat_t [`GCN_FEATS-1:0][`GCN_CLASSES-1:0] weight_tab,
    input  logic                                     feat_re,
    input  col_addr_t                                feat_addr,
    input  class_idx_t [`GCN_NODES-1:0]              y,
    input  logic                                     done,
    output int                                       errors,
    output int                                       results
);

    class_idx_t [`GCN_NODES-1:0] exp_y;
    logic busy;          // a run was accepted and has not finished
    logic done_q;
    logic drop_chk;      // done must be low one cycle after an accepted start
    logic after_reset;
    int   feat_cnt;

    task automatic report_value(input string sig, input int got, input int want);
        $display("** Error at %0t: %s = %0d, expected %0d", $time, sig, got, want);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model of one run
    ////////////////////////////////////////////////////////////////////////////
    task automatic predict();
        bit nbr [`GCN_NODES][`GCN_NODES];
        int sc [`GCN_NODES][`GCN_CLASSES];
        int a, b, s, best;
        nbr = '{default: 0};
        sc  = '{default: 0};
        for (int e = 0; e < `GCN_EDGES; e++) begin
            a = int'(edge_src[e]);
            b = int'(edge_dst[e]);
            if (a != 0 && b != 0) begin   // id 0 is an empty slot
                nbr[a-1][b-1] = 1'b1;
                nbr[b-1][a-1] = 1'b1;
            end
        end
        for (int f = 0; f < `GCN_FEATS; f++)
            for (int n = 0; n < `GCN_NODES; n++) begin
                s = 0;
                for (int m = 0; m < `GCN_NODES; m++)
                    if (nbr[n][m])
                        s += int'(feat_tab[f][m]);
                for (int c = 0; c < `GCN_CLASSES; c++)
                    sc[n][c] += s * int'(weight_tab[f][c]);
            end
        for (int n = 0; n < `GCN_NODES; n++) begin
            best = 0;
            for (int c = 1; c < `GCN_CLASSES; c++)
                if (sc[n][c] > sc[n][best])   // ties stay with the lower class
                    best = c;
            exp_y[n] = class_idx_t'(best);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        = 1'b0;
            done_q      = 1'b0;
            drop_chk    = 1'b0;
            after_reset = 1'b1;
            feat_cnt    = 0;
            errors      = 0;
            results     = 0;
        end else begin
            if (after_reset) begin
                if (done)
                    report_value("done", 1, 0);
                if (feat_re)
                    report_value("feat_re", 1, 0);
                if (y != '0)
                    report_value("y", int'(y), 0);
                after_reset = 1'b0;
            end
            if (drop_chk && done)
                report_value("done", 1, 0);
            drop_chk = 1'b0;
            if (start && !busy) begin   // start is only taken while idle
                predict();
                busy     = 1'b1;
                drop_chk = 1'b1;
                feat_cnt = 0;
            end
            if (feat_re) begin
                if (!busy) begin
                    $display("feat_re went high at %0t with no run in progress", $time);
                    errors++;
                end else if (feat_addr != col_addr_t'(feat_cnt)) begin
                    report_value("feat_addr", int'(feat_addr), feat_cnt);
                end
                feat_cnt++;
            end
            if (done && !done_q) begin
                if (!busy) begin
                    $display("done rose at %0t with no run in progress", $time);
                    errors++;
                end else begin
                    for (int n = 0; n < `GCN_NODES; n++)
                        if (y[n] != exp_y[n])
                            report_value($sformatf("y[%0d]", n), int'(y[n]), int'(exp_y[n]));
                    if (feat_cnt != `GCN_FEATS)
                        report_value("feat_re cycles", feat_cnt, `GCN_FEATS);
                    results++;
                end
                busy = 1'b0;   // idle again one cycle after done
            end
            done_q = done;
        end
    end

endmodule

// ==== tb_gcn.sv ====
`timescale 1ns/1ps
`include "gcn_settings.svh"

module tb_gcn
    import gcn_pkg::*;
();

    localparam int RUNS        = 24;
    localparam int CYCLE_LIMIT =
        RUNS * (`GCN_EDGES + `GCN_FEATS + `GCN_CLASSES + 20) + 100;

    logic                          clk;
    logic                          rst_n;
    logic                          start;
    node_id_t [`GCN_EDGES-1:0]     edge_src;
    node_id_t [`GCN_EDGES-1:0]     edge_dst;
    feat_t [`GCN_NODES-1:0]        feat_col = '0;
    feat_t [`GCN_CLASSES-1:0]      weight_row = '0;
    logic                          feat_re;
    col_addr_t                     feat_addr;
    class_idx_t [`GCN_NODES-1:0]   y;
    logic                          done;

    feat_t [`GCN_FEATS-1:0][`GCN_NODES-1:0]   feat_tab;
    feat_t [`GCN_FEATS-1:0][`GCN_CLASSES-1:0] weight_tab;
    logic      rd_pend = 1'b0;   // read issued last cycle
    col_addr_t rd_addr = '0;
    integer    seed;
    int        cycles = 0;
    int        test_no;
    int        err_mark;
    int        tb_errors;
    int        errors;
    int        results;

    gcn_top i_dut (
        .clk(clk), .rst_n(rst_n), .start(start),
        .edge_src(edge_src), .edge_dst(edge_dst),
        .feat_col(feat_col), .weight_row(weight_row),
        .feat_re(feat_re), .feat_addr(feat_addr), .y(y), .done(done)
    );

    gcn_checker i_check (
        .clk(clk), .rst_n(rst_n), .start(start),
        .edge_src(edge_src), .edge_dst(edge_dst),
        .feat_tab(feat_tab), .weight_tab(weight_tab),
        .feat_re(feat_re), .feat_addr(feat_addr), .y(y), .done(done),
        .errors(errors), .results(results)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a result never arrived", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // feature and weight memories answer one cycle after the read
    always @(negedge clk) begin
        if (rd_pend) begin
            feat_col   = feat_tab[rd_addr];
            weight_row = weight_tab[rd_addr];
        end else begin
            feat_col   = '0;
            weight_row = '0;
        end
        rd_pend = feat_re;
        rd_addr = feat_addr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic fill_tables();
        for (int f = 0; f < `GCN_FEATS; f++) begin
            for (int n = 0; n < `GCN_NODES; n++)
                feat_tab[f][n] = feat_t'(rand_below(32));
            for (int c = 0; c < `GCN_CLASSES; c++)
                weight_tab[f][c] = feat_t'(rand_below(32));
        end
    endtask

    task automatic pick_random_graph();
        for (int e = 0; e < `GCN_EDGES; e++) begin
            edge_src[e] = node_id_t'(rand_below(`GCN_NODES + 1));   // 0 leaves a gap
            edge_dst[e] = node_id_t'(rand_below(`GCN_NODES + 1));
        end
    endtask

    task automatic issue_start();   // called on a falling edge
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        while (!done)
            @(negedge clk);
        @(negedge clk);   // checker compares on the next rising edge
    endtask

    task automatic close_test(input string name);
        test_no++;
        if (errors == err_mark)
            $display("test %0d, %s: passed", test_no, name);
        else
            $display("test %0d, %s: FAILED with %0d errors", test_no, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        edge_src   = '0;
        edge_dst   = '0;
        feat_tab   = '0;
        weight_tab = '0;
        seed       = 32'h794b_61d6;
        test_no    = 0;
        err_mark   = 0;
        tb_errors  = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        close_test("idle after reset");

        fill_tables();
        edge_src[0] = node_id_t'(1);
        edge_dst[0] = node_id_t'(2);
        issue_start();
        wait_for_done();
        close_test("single edge");

        for (int r = 0; r < 20; r++) begin
            fill_tables();
            pick_random_graph();
            issue_start();
            wait_for_done();
        end
        close_test("random graphs");

        fill_tables();
        edge_src = '0;
        edge_dst = '0;
        issue_start();
        wait_for_done();
        close_test("empty edge list");

        fill_tables();
        pick_random_graph();
        issue_start();
        repeat (5) @(negedge clk);
        pick_random_graph();
        issue_start();   // busy, must be ignored
        wait_for_done();
        issue_start();   // second list, now accepted
        wait_for_done();
        close_test("start while busy");

        if (results != RUNS) begin
            $display("only %0d of %0d runs produced a checked result", results, RUNS);
            tb_errors++;
        end
        $display("tests %0d, results checked %0d, errors %0d",
                 test_no, results, errors + tb_errors);
        if (errors + tb_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
gcn_pkg.sv
gcn_sequencer.sv
gcn_adjacency.sv
gcn_aggregate.sv
gcn_transform.sv
gcn_argmax.sv
gcn_top.sv
gcn_checker.sv
tb_gcn.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_gcn -f compile.f -Mdir obj_dir
	out=$$(./obj_dir/Vtb_gcn); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
